/* design/nf_pkg.sv */
/*
 RV32I subset only: no byte or halfword access, no jal/jalr, auipc or CSRs.
 Data memory is word addressed, dmem_depth words from address 0.
*/

package nf_pkg;

    localparam int xlen       = 32;                   // data and address width
    localparam int reg_addr_w = 5;                    // register index width
    localparam int dmem_depth = 256;                  // data memory words
    localparam int dmem_aw    = $clog2(dmem_depth);   // word index width

    // major opcodes
    localparam logic [6 : 0] opc_op     = 7'b0110011; // r-type alu
    localparam logic [6 : 0] opc_op_imm = 7'b0010011; // i-type alu
    localparam logic [6 : 0] opc_lui    = 7'b0110111; // load upper immediate
    localparam logic [6 : 0] opc_load   = 7'b0000011; // lw only
    localparam logic [6 : 0] opc_store  = 7'b0100011; // sw only
    localparam logic [6 : 0] opc_branch = 7'b1100011; // beq, bne

    // funct3 values
    localparam logic [2 : 0] f3_add_sub = 3'd0;       // add, sub, addi
    localparam logic [2 : 0] f3_sll     = 3'd1;       // sll, slli
    localparam logic [2 : 0] f3_slt     = 3'd2;
    localparam logic [2 : 0] f3_xor     = 3'd4;
    localparam logic [2 : 0] f3_srl     = 3'd5;
    localparam logic [2 : 0] f3_or      = 3'd6;       // or, ori
    localparam logic [2 : 0] f3_and     = 3'd7;
    localparam logic [2 : 0] f3_word    = 3'd2;       // lw, sw width
    localparam logic [2 : 0] f3_beq     = 3'd0;
    localparam logic [2 : 0] f3_bne     = 3'd1;

    // funct7 values
    localparam logic [6 : 0] f7_base    = 7'h00;
    localparam logic [6 : 0] f7_alt     = 7'h20;      // sub

    typedef logic [6 : 0]              opcode_t;
    typedef logic [2 : 0]              funct3_t;
    typedef logic [6 : 0]              funct7_t;
    typedef logic [reg_addr_w - 1 : 0] reg_idx_t;

    typedef enum logic [3 : 0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_code_t;

    typedef enum logic [1 : 0] {imm_i, imm_s, imm_b, imm_u} imm_sel_t;

    typedef struct packed {
        funct7_t funct7; reg_idx_t rs2; reg_idx_t rs1;
        funct3_t funct3; reg_idx_t rd;  opcode_t  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11 : 0] imm; reg_idx_t rs1; funct3_t funct3;
        reg_idx_t rd; opcode_t opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6 : 0] imm_hi; reg_idx_t rs2; reg_idx_t rs1;
        funct3_t funct3; logic [4 : 0] imm_lo; opcode_t opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm12; logic [5 : 0] imm10_5; reg_idx_t rs2; reg_idx_t rs1;
        funct3_t funct3; logic [3 : 0] imm4_1; logic imm11; opcode_t opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19 : 0] imm; reg_idx_t rd; opcode_t opcode;
    } u_fmt_t;

    // one instruction word, five views
    typedef union packed {
        r_fmt_t r; i_fmt_t i; s_fmt_t s; b_fmt_t b; u_fmt_t u;
    } instr_u;

    typedef struct packed {
        logic      we_rf;      // register write
        logic      we_dm;      // data memory write
        logic      rf_src;     // 1 = load data to rf
        logic      src_b_sel;  // 1 = immediate as operand b
        logic      branch;     // conditional branch
        logic      branch_ne;  // bne rather than beq
        alu_code_t alu_code;
    } ctrl_t;

endpackage : nf_pkg

/* design/nf_dmem_if.sv */
/*
 No handshake: write lands at the clock edge when we is high,
 read data is valid combinationally in the address cycle.
*/
`timescale 1ns/1ps

interface nf_dmem_if;

    logic [nf_pkg::xlen - 1 : 0] addr;  // byte address, word aligned
    logic                        we;    // write enable
    logic [nf_pkg::xlen - 1 : 0] wd;    // write data
    logic [nf_pkg::xlen - 1 : 0] rd;    // read data

    modport cpu (
        output addr,
        output we,
        output wd,
        input  rd
    );

    modport mem (
        input  addr,
        input  we,
        input  wd,
        output rd
    );

endinterface : nf_dmem_if

/* design/nf_reg_file.sv */
/*
 31 writable registers, x0 hardwired to zero. Contents are not reset.
 Port 0 is a combinational debug scan.
*/
`timescale 1ns/1ps

module nf_reg_file (
    input  logic                              clk,
    input  logic [nf_pkg::reg_addr_w - 1 : 0] ra1,  // read port 1
    output logic [nf_pkg::xlen - 1 : 0]       rd1,
    input  logic [nf_pkg::reg_addr_w - 1 : 0] ra2,  // read port 2
    output logic [nf_pkg::xlen - 1 : 0]       rd2,
    input  logic [nf_pkg::reg_addr_w - 1 : 0] wa3,  // write port
    input  logic [nf_pkg::xlen - 1 : 0]       wd3,
    input  logic                              we3,
    input  logic [nf_pkg::reg_addr_w - 1 : 0] ra0,  // scan port
    output logic [nf_pkg::xlen - 1 : 0]       rd0
);

    logic [nf_pkg::xlen - 1 : 0] regs [1 : 31];    // no storage for x0

    function automatic logic [nf_pkg::xlen - 1 : 0] read_reg(
        input logic [nf_pkg::reg_addr_w - 1 : 0] ra
    );
        return (ra == '0) ? '0 : regs[ra];          // x0 reads zero
    endfunction

    assign rd1 = read_reg(ra1);
    assign rd2 = read_reg(ra2);
    assign rd0 = read_reg(ra0);

    always_ff @(posedge clk) begin
        if (we3 && (wa3 != '0)) begin               // drop writes to x0
            regs[wa3] <= wd3;
        end
    end

endmodule : nf_reg_file

/* design/nf_alu.sv */
/*
 Purely combinational. slt is signed; srl is logical.
 Shift amount comes in on shamt, picked by the core for imm or reg forms.
*/
`timescale 1ns/1ps

module nf_alu (
    input  logic [nf_pkg::xlen - 1 : 0] src_a,     // operand a, rs1
    input  logic [nf_pkg::xlen - 1 : 0] src_b,     // operand b, rs2 or imm
    input  logic [4 : 0]                shamt,     // shift amount
    input  nf_pkg::alu_code_t           alu_code,  // from decoder
    output logic [nf_pkg::xlen - 1 : 0] result
);

    logic lt;                                      // signed less-than

    assign lt = $signed(src_a) < $signed(src_b);

    always_comb begin
        case (alu_code)
            nf_pkg::alu_add : begin
                result = src_a + src_b;
            end
            nf_pkg::alu_sub : begin
                result = src_a - src_b;
            end
            nf_pkg::alu_and : begin
                result = src_a & src_b;
            end
            nf_pkg::alu_or : begin
                result = src_a | src_b;
            end
            nf_pkg::alu_xor : begin
                result = src_a ^ src_b;
            end
            nf_pkg::alu_slt : begin
                result = {{(nf_pkg::xlen - 1){1'b0}}, lt};  // 0 or 1
            end
            nf_pkg::alu_sll : begin
                result = src_a << shamt;
            end
            nf_pkg::alu_srl : begin
                result = src_a >> shamt;                     // zero fill
            end
            nf_pkg::alu_pass_b : begin
                result = src_b;                              // lui
            end
            default : begin
                result = '0;
            end
        endcase
    end

endmodule : nf_alu

/* design/nf_decoder.sv */
/*
 Unsupported opcodes and funct codes decode with all write enables low.
 The B immediate is in half-word units; the core doubles it.
*/
`timescale 1ns/1ps

module nf_decoder (
    input  nf_pkg::instr_u              instr,  // fetched word
    output nf_pkg::ctrl_t               ctrl,   // control bundle
    output logic [nf_pkg::xlen - 1 : 0] imm     // sign-extended immediate
);

    nf_pkg::imm_sel_t imm_sel;

    always_comb begin
        ctrl          = '0;
        ctrl.alu_code = nf_pkg::alu_add;  // address calc default
        imm_sel       = nf_pkg::imm_i;
        case (instr.r.opcode)
            nf_pkg::opc_op : begin
                ctrl.we_rf = 1'b1;
                case (instr.r.funct3)
                    nf_pkg::f3_add_sub : ctrl.alu_code = instr.r.funct7[5] ? nf_pkg::alu_sub
                                                                          : nf_pkg::alu_add;
                    nf_pkg::f3_sll     : ctrl.alu_code = nf_pkg::alu_sll;
                    nf_pkg::f3_slt     : ctrl.alu_code = nf_pkg::alu_slt;
                    nf_pkg::f3_xor     : ctrl.alu_code = nf_pkg::alu_xor;
                    nf_pkg::f3_srl     : ctrl.alu_code = nf_pkg::alu_srl;
                    nf_pkg::f3_or      : ctrl.alu_code = nf_pkg::alu_or;
                    nf_pkg::f3_and     : ctrl.alu_code = nf_pkg::alu_and;
                    default            : ctrl.we_rf    = 1'b0;  // sltu
                endcase
                // only sub may set funct7, sra and friends are no-ops
                if ((instr.r.funct7 != nf_pkg::f7_base) &&
                    !((instr.r.funct7 == nf_pkg::f7_alt) &&
                      (instr.r.funct3 == nf_pkg::f3_add_sub))) begin
                    ctrl.we_rf = 1'b0;
                end
            end
            nf_pkg::opc_op_imm : begin
                ctrl.we_rf     = 1'b1;
                ctrl.src_b_sel = 1'b1;
                case (instr.i.funct3)
                    nf_pkg::f3_add_sub : ctrl.alu_code = nf_pkg::alu_add;  // addi
                    nf_pkg::f3_or      : ctrl.alu_code = nf_pkg::alu_or;   // ori
                    nf_pkg::f3_sll     : begin                             // slli
                        ctrl.alu_code = nf_pkg::alu_sll;
                        ctrl.we_rf    = (instr.r.funct7 == nf_pkg::f7_base);
                    end
                    default            : ctrl.we_rf    = 1'b0;
                endcase
            end
            nf_pkg::opc_lui : begin
                ctrl.we_rf     = 1'b1;
                ctrl.src_b_sel = 1'b1;
                ctrl.alu_code  = nf_pkg::alu_pass_b;
                imm_sel        = nf_pkg::imm_u;
            end
            nf_pkg::opc_load : begin
                ctrl.we_rf     = (instr.i.funct3 == nf_pkg::f3_word);  // lw only
                ctrl.rf_src    = 1'b1;
                ctrl.src_b_sel = 1'b1;
            end
            nf_pkg::opc_store : begin
                ctrl.we_dm     = (instr.s.funct3 == nf_pkg::f3_word);  // sw only
                ctrl.src_b_sel = 1'b1;
                imm_sel        = nf_pkg::imm_s;
            end
            nf_pkg::opc_branch : begin
                ctrl.branch    = (instr.b.funct3 == nf_pkg::f3_beq) ||
                                 (instr.b.funct3 == nf_pkg::f3_bne);
                ctrl.branch_ne = (instr.b.funct3 == nf_pkg::f3_bne);
                imm_sel        = nf_pkg::imm_b;
            end
            default : begin
                ctrl = '0;                                 // executes as nop
            end
        endcase
    end

    always_comb begin
        case (imm_sel)
            nf_pkg::imm_s : imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            nf_pkg::imm_b : imm = {{20{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                                   instr.b.imm10_5, instr.b.imm4_1};  // half-words
            nf_pkg::imm_u : imm = {instr.u.imm, 12'b0};
            default       : imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

endmodule : nf_decoder

/* design/nf_cpu.sv */
/*
 Single cycle, one instruction per clk with cpu_en high, no stalls.
 Writes are blocked while arst_n is low or cpu_en is low.
*/
`timescale 1ns/1ps

module nf_cpu (
    input  logic                              clk,
    input  logic                              arst_n,      // async, active low
    input  logic                              cpu_en,      // freezes core when low
    output logic [nf_pkg::xlen - 1 : 0]       instr_addr,  // pc
    input  logic [nf_pkg::xlen - 1 : 0]       instr,       // word at pc
    nf_dmem_if.cpu                            dmem,        // data memory
    input  logic [nf_pkg::reg_addr_w - 1 : 0] reg_addr,    // debug scan index
    output logic [nf_pkg::xlen - 1 : 0]       reg_data     // debug scan data
);

    nf_pkg::instr_u              instr_w;     // fields by view
    nf_pkg::ctrl_t               ctrl;
    logic [nf_pkg::xlen - 1 : 0] imm;         // from decoder
    logic [nf_pkg::xlen - 1 : 0] rd1;
    logic [nf_pkg::xlen - 1 : 0] rd2;
    logic [nf_pkg::xlen - 1 : 0] wd3;
    logic [nf_pkg::xlen - 1 : 0] src_b;
    logic [4 : 0]                shamt;
    logic [nf_pkg::xlen - 1 : 0] result;      // alu output
    logic                        wr_ok;       // core may commit this cycle
    logic                        taken;       // branch taken
    logic [nf_pkg::xlen - 1 : 0] pc_next;

    assign instr_w = instr;
    assign wr_ok   = cpu_en && arst_n;        // no writes in reset or freeze

    // operand b and shift amount
    assign src_b = ctrl.src_b_sel ? imm : rd2;
    assign shamt = ctrl.src_b_sel ? instr_w.r.rs2 : rd2[4 : 0];  // slli vs sll

    // write-back source
    assign wd3 = ctrl.rf_src ? dmem.rd : result;

    // data memory side
    assign dmem.addr = result;                // rs1 + imm
    assign dmem.wd   = rd2;
    assign dmem.we   = ctrl.we_dm && wr_ok;

    // branch compare on raw read operands
    assign taken = ctrl.branch && (ctrl.branch_ne ? (rd1 != rd2) : (rd1 == rd2));

    assign pc_next = taken ? instr_addr + (imm << 1)  // b imm is half-words
                           : instr_addr + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_addr <= '0;
        end else if (cpu_en) begin
            instr_addr <= pc_next;
        end
    end

    nf_reg_file reg_file_0 (
        .clk  (clk),
        .ra1  (instr_w.r.rs1),
        .rd1  (rd1),
        .ra2  (instr_w.r.rs2),
        .rd2  (rd2),
        .wa3  (instr_w.r.rd),
        .wd3  (wd3),
        .we3  (ctrl.we_rf && wr_ok),
        .ra0  (reg_addr),
        .rd0  (reg_data)
    );

    nf_alu alu_0 (
        .src_a    (rd1),
        .src_b    (src_b),
        .shamt    (shamt),
        .alu_code (ctrl.alu_code),
        .result   (result)
    );

    nf_decoder decoder_0 (
        .instr (instr_w),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    // pc must stay on word boundaries, branch targets included
    pc_aligned_a : assert property (
        @(posedge clk) disable iff (!arst_n) instr_addr[1 : 0] == 2'b00
    ) else $error("misaligned instr_addr %h", instr_addr);

endmodule : nf_cpu

/* design/nf_data_mem.sv */
/*
 dmem_depth words, index from address bits dmem_aw+1 down to 2.
 Read is combinational, write is clocked. Contents are not reset.
*/
`timescale 1ns/1ps

module nf_data_mem (
    input  logic   clk,
    nf_dmem_if.mem bus    // from cpu
);

    logic [nf_pkg::xlen - 1 : 0]    mem [nf_pkg::dmem_depth];
    logic [nf_pkg::dmem_aw - 1 : 0] idx;  // word index

    assign idx    = bus.addr[nf_pkg::dmem_aw + 1 : 2];
    assign bus.rd = mem[idx];               // same-cycle read

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[idx] <= bus.wd;
        end
    end

    // sw from the core must hit an aligned word inside the array
    dm_wr_addr_a : assert property (
        @(posedge clk) bus.we |->
            (bus.addr[1 : 0] == 2'b00) && (bus.addr < nf_pkg::dmem_depth * 4)
    ) else $error("bad data memory write address %h", bus.addr);

endmodule : nf_data_mem

/* design/nf_top.sv */
/*
 Instruction memory lives outside; the program is served on instr.
 Debug scan reads any register combinationally.
*/
`timescale 1ns/1ps

module nf_top (
    input  logic                              clk,
    input  logic                              arst_n,      // async, active low
    input  logic                              cpu_en,      // one instr per enabled edge
    output logic [nf_pkg::xlen - 1 : 0]       instr_addr,  // to external imem
    input  logic [nf_pkg::xlen - 1 : 0]       instr,       // from external imem
    input  logic [nf_pkg::reg_addr_w - 1 : 0] reg_addr,    // scan index
    output logic [nf_pkg::xlen - 1 : 0]       reg_data     // scan data
);

    nf_dmem_if dmem_if ();                   // cpu to data memory

    nf_cpu cpu_0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_en     (cpu_en),
        .instr_addr (instr_addr),
        .instr      (instr),
        .dmem       (dmem_if.cpu),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data)
    );

    nf_data_mem data_mem_0 (
        .clk (clk),
        .bus (dmem_if.mem)
    );

endmodule : nf_top

/* tb/nf_tb.sv */
/*
 Program is built at time zero and served on instr. cpu_en drops at random.
 Registers and data memory start unknown, so the golden model starts unknown too.
*/
`timescale 1ns/1ps

module nf_tb;

    logic          clk;
    logic          arst_n;
    logic          cpu_en;
    logic [31 : 0] instr_addr;
    logic [31 : 0] instr;
    logic [4 : 0]  reg_addr;
    logic [31 : 0] reg_data;

    logic [31 : 0] prog [256];    // instruction image, word indexed
    logic [31 : 0] regs_m [32];   // golden registers
    logic [31 : 0] mem_m [256];   // golden data memory
    logic [31 : 0] pc_m;          // golden pc
    logic [31 : 0] exp_scan;      // expected scan value
    logic [31 : 0] lfsr;
    logic [31 : 0] end_addr;      // first address past the program
    int            err_cnt;
    int            n;             // next free program slot

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    nf_top nf_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_en     (cpu_en),
        .instr_addr (instr_addr),
        .instr      (instr),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data)
    );

    assign instr    = prog[instr_addr[9 : 2]];  // external imem
    assign exp_scan = regs_m[reg_addr];

    // galois lfsr, one step per bit taken
    function automatic logic [31 : 0] lfsr_bits(input int nbits);
        logic [31 : 0] v;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30 : 0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31 : 0] r_word(input logic [6 : 0] f7, input logic [2 : 0] f3,
        input logic [4 : 0] rd, input logic [4 : 0] rs1, input logic [4 : 0] rs2);
        return {f7, rs2, rs1, f3, rd, nf_pkg::opc_op};
    endfunction

    function automatic logic [31 : 0] i_word(input logic [6 : 0] opc, input logic [2 : 0] f3,
        input logic [4 : 0] rd, input logic [4 : 0] rs1, input logic [11 : 0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31 : 0] sw_word(input logic [4 : 0] rs2, input logic [4 : 0] rs1,
        input logic [11 : 0] off);
        return {off[11 : 5], rs2, rs1, nf_pkg::f3_word, off[4 : 0], nf_pkg::opc_store};
    endfunction

    function automatic logic [31 : 0] b_word(input logic [2 : 0] f3, input logic [4 : 0] rs1,
        input logic [4 : 0] rs2, input logic [12 : 0] off);
        return {off[12], off[10 : 5], rs2, rs1, f3, off[4 : 1], off[11], nf_pkg::opc_branch};
    endfunction

    task automatic put(input logic [31 : 0] w);
        prog[n] = w;
        n       = n + 1;
    endtask

    task automatic load_const(input logic [4 : 0] rd, input logic [31 : 0] c);
        logic [31 : 0] hi;
        hi = c + 32'h800;  // addi sign-extends the low 12 bits
        put({hi[31 : 12], rd, nf_pkg::opc_lui});
        put(i_word(nf_pkg::opc_op_imm, 3'd0, rd, rd, c[11 : 0]));
    endtask

    task automatic build_program();
        logic [31 : 0] r;
        for (int k = 0; k < 256; k++) begin
            prog[k] = i_word(nf_pkg::opc_op_imm, 3'd0, 5'd0, 5'd0, k[11 : 0]);  // nop fill
        end
        n = 0;
        load_const(5'd1, lfsr_bits(32) | 32'h8000_0000);  // negative
        load_const(5'd2, lfsr_bits(32) & 32'h7fff_ffff);  // positive
        load_const(5'd3, lfsr_bits(32));
        put(r_word(7'h00, 3'd0, 5'd5, 5'd1, 5'd2));   // add
        put(r_word(7'h20, 3'd0, 5'd6, 5'd1, 5'd2));   // sub
        put(r_word(7'h00, 3'd7, 5'd7, 5'd1, 5'd2));   // and
        put(r_word(7'h00, 3'd6, 5'd8, 5'd1, 5'd2));   // or
        put(r_word(7'h00, 3'd4, 5'd9, 5'd1, 5'd2));   // xor
        put(r_word(7'h00, 3'd2, 5'd10, 5'd1, 5'd2));  // slt, neg < pos
        put(r_word(7'h00, 3'd2, 5'd11, 5'd2, 5'd1));  // slt, pos < neg
        put(r_word(7'h00, 3'd1, 5'd12, 5'd1, 5'd3));  // sll by x3[4:0]
        put(r_word(7'h00, 3'd5, 5'd13, 5'd1, 5'd3));  // srl by x3[4:0]
        r = lfsr_bits(12);
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd14, 5'd1, r[11 : 0]));         // addi
        r = lfsr_bits(12);
        put(i_word(nf_pkg::opc_op_imm, 3'd6, 5'd15, 5'd2, r[11 : 0]));         // ori
        r = lfsr_bits(5);
        put(i_word(nf_pkg::opc_op_imm, 3'd1, 5'd16, 5'd1, {7'd0, r[4 : 0]}));  // slli
        put(r_word(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));                           // x0 targets
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd0, 5'd3, 12'h7ff));
        put({20'hfffff, 5'd0, nf_pkg::opc_lui});
        r = lfsr_bits(7);
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd17, 5'd0, {3'd0, r[6 : 0], 2'd0}));  // base
        put(sw_word(5'd5, 5'd17, 12'd0));
        put(sw_word(5'd9, 5'd17, 12'd4));
        put(i_word(nf_pkg::opc_load, nf_pkg::f3_word, 5'd18, 5'd17, 12'd0));
        put(i_word(nf_pkg::opc_load, nf_pkg::f3_word, 5'd19, 5'd17, 12'd4));
        put(sw_word(5'd13, 5'd17, 12'd8));
        put(r_word(7'h00, 3'd0, 5'd18, 5'd18, 5'd19));
        put(i_word(nf_pkg::opc_load, nf_pkg::f3_word, 5'd20, 5'd17, 12'd8));
        put(b_word(nf_pkg::f3_beq, 5'd1, 5'd1, 13'd12));                      // taken
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd21, 5'd0, 12'd1));            // skipped
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd22, 5'd0, 12'd2));            // skipped
        put(b_word(nf_pkg::f3_bne, 5'd1, 5'd1, 13'd8));                       // not taken
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd21, 5'd0, 12'd5));
        put(b_word(nf_pkg::f3_beq, 5'd1, 5'd2, 13'd8));                       // not taken
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd22, 5'd0, 12'd7));
        put(b_word(nf_pkg::f3_bne, 5'd1, 5'd2, 13'd12));                      // taken
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd23, 5'd0, 12'd3));            // skipped
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd23, 5'd0, 12'd4));            // skipped
        put(i_word(nf_pkg::opc_op_imm, 3'd0, 5'd24, 5'd0, 12'd9));
        put(i_word(nf_pkg::opc_load, nf_pkg::f3_word, 5'd25, 5'd17, 12'd4));  // reload
        end_addr = n * 4;
    endtask

    // isa rules for one retired word
    task automatic retire(input logic [31 : 0] w);
        logic [31 : 0] a;
        logic [31 : 0] b;
        logic [31 : 0] imm;
        logic [31 : 0] ea;
        logic [31 : 0] res;
        logic [31 : 0] nxt;
        logic          wr;
        a   = regs_m[w[19 : 15]];
        b   = regs_m[w[24 : 20]];
        imm = {{20{w[31]}}, w[31 : 20]};
        res = '0;
        wr  = 1'b0;
        nxt = pc_m + 32'd4;
        case (w[6 : 0])
            nf_pkg::opc_op : begin
                wr = 1'b1;
                case ({w[31 : 25], w[14 : 12]})
                    10'h000 : res = a + b;
                    10'h100 : res = a - b;
                    10'h001 : res = a << b[4 : 0];
                    10'h002 : res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    10'h004 : res = a ^ b;
                    10'h005 : res = a >> b[4 : 0];
                    10'h006 : res = a | b;
                    10'h007 : res = a & b;
                    default : wr = 1'b0;
                endcase
            end
            nf_pkg::opc_op_imm : begin
                wr  = (w[14 : 12] == 3'd0) || (w[14 : 12] == 3'd6) ||
                      ((w[14 : 12] == 3'd1) && (w[31 : 25] == 7'd0));
                res = (w[14 : 12] == 3'd0) ? a + imm :
                      (w[14 : 12] == 3'd6) ? a | imm : a << w[24 : 20];
            end
            nf_pkg::opc_lui : begin
                wr  = 1'b1;
                res = {w[31 : 12], 12'd0};
            end
            nf_pkg::opc_load : begin
                ea  = a + imm;
                wr  = (w[14 : 12] == 3'd2);
                res = mem_m[ea[9 : 2]];
            end
            nf_pkg::opc_store : begin
                ea = a + {{20{w[31]}}, w[31 : 25], w[11 : 7]};
                if (w[14 : 12] == 3'd2) begin
                    mem_m[ea[9 : 2]] <= b;
                end
            end
            nf_pkg::opc_branch : begin
                if (((w[14 : 12] == 3'd0) && (a == b)) || ((w[14 : 12] == 3'd1) && (a != b))) begin
                    nxt = pc_m + {{19{w[31]}}, w[31], w[7], w[30 : 25], w[11 : 8], 1'b0};
                end
            end
            default : ;                     // unknown opcode, no-op
        endcase
        if (wr && (w[11 : 7] != 5'd0)) begin
            regs_m[w[11 : 7]] <= res;       // x0 never written
        end
        pc_m <= nxt;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_m <= '0;
        end else if (cpu_en) begin
            retire(prog[pc_m[9 : 2]]);
        end
    end

    pc_match_a : assert property (@(posedge clk) disable iff (!arst_n) instr_addr === pc_m)
        else begin
            err_cnt++;
            $display("[FAIL] %0t instr_addr: expected %h, got %h",
                     $time, $sampled(pc_m), $sampled(instr_addr));
        end

    scan_match_a : assert property (@(posedge clk) disable iff (!arst_n) reg_data === exp_scan)
        else begin
            err_cnt++;
            $display("[FAIL] %0t reg_data x%0d: expected %h, got %h",
                     $time, $sampled(reg_addr), $sampled(exp_scan), $sampled(reg_data));
        end

    initial begin
        int cycles;
        err_cnt   = 0;
        lfsr      = 32'he0d8;
        regs_m[0] = '0;
        arst_n    = 1'b0;
        cpu_en    = 1'b0;
        reg_addr  = 5'd0;
        build_program();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        cpu_en = 1'b1;
        cycles = 0;
        while ((instr_addr < end_addr) && (cycles < 400)) begin
            @(negedge clk);
            cpu_en   = (lfsr_bits(2) != '0);  // low about one cycle in four
            reg_addr = reg_addr + 5'd1;
            cycles++;
        end
        if (instr_addr < end_addr) begin
            err_cnt++;
            $display("timeout: program did not reach its end within 400 cycles");
        end
        cpu_en = 1'b1;
        for (int k = 0; k < 64; k++) begin   // final sweep over every register
            @(negedge clk);
            reg_addr = k[4 : 0];
        end
        $display("check run complete, %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : nf_tb

/* sim.f */
design/nf_pkg.sv
design/nf_dmem_if.sv
design/nf_reg_file.sv
design/nf_alu.sv
design/nf_decoder.sv
design/nf_cpu.sv
design/nf_data_mem.sv
design/nf_top.sv
tb/nf_tb.sv

/* Bender.yml */
package:
  name: nf_core

sources:
  - files:
      - design/nf_pkg.sv
      - design/nf_dmem_if.sv
      - design/nf_reg_file.sv
      - design/nf_alu.sv
      - design/nf_decoder.sv
      - design/nf_cpu.sv
      - design/nf_data_mem.sv
      - design/nf_top.sv

  - target: simulation
    files:
      - tb/nf_tb.sv
